// File: logic/addr_decoder.sv
`timescale 1ns/1ns

module addr_decoder (
    input  logic   clk,
    input  logic   reset,
    axil_if.slave  upstream,
    axil_if.master targets [fabric_map_pkg::NUM_TARGETS]
);
    import axil_pkg::*;
    import fabric_map_pkg::*;

    target_t hit_tgt;
    target_t tgt_sel;
    addr_t   off0;
    addr_t   off1;
    addr_t   hit_off;

    logic  busy;       // one transaction held until its response leaves
    logic  fwd_valid;
    logic  fwd_ready;
    logic  err_valid;
    logic  q_write;
    addr_t q_addr;
    data_t q_wdata;

    logic [NUM_TARGETS-1:0] t_req_ready;
    logic [NUM_TARGETS-1:0] t_rsp_valid;
    data_t                  t_rsp_rdata [NUM_TARGETS];
    resp_t                  t_rsp_resp  [NUM_TARGETS];

    logic up_req_xfer;
    logic up_rsp_xfer;

    // unsigned offsets wrap below the base, so one compare per window
    assign off0 = upstream.req_addr - MEM0_BASE;
    assign off1 = upstream.req_addr - MEM1_BASE;

    always_comb begin
        hit_tgt = TGT_NONE;
        hit_off = '0;
        if (off0 < MEM0_BYTES) begin
            hit_tgt = TGT_MEM0;
            hit_off = off0;
        end else if (off1 < MEM1_BYTES) begin
            hit_tgt = TGT_MEM1;
            hit_off = off1;
        end
    end

    for (genvar i = 0; i < NUM_TARGETS; i++) begin : g_target
        assign targets[i].req_valid = fwd_valid && (tgt_sel == target_t'(i));
        assign targets[i].req_write = q_write;
        assign targets[i].req_addr  = q_addr;
        assign targets[i].req_wdata = q_wdata;
        assign targets[i].rsp_ready = upstream.rsp_ready && (tgt_sel == target_t'(i));

        assign t_req_ready[i] = targets[i].req_ready;
        assign t_rsp_valid[i] = targets[i].rsp_valid;
        assign t_rsp_rdata[i] = targets[i].rsp_rdata;
        assign t_rsp_resp[i]  = targets[i].rsp_resp;
    end

    always_comb begin
        fwd_ready          = 1'b0;
        upstream.rsp_valid = err_valid;
        upstream.rsp_rdata = '0;
        upstream.rsp_resp  = RESP_DECERR;
        case (tgt_sel)
            TGT_MEM0: begin
                fwd_ready          = t_req_ready[0];
                upstream.rsp_valid = t_rsp_valid[0];
                upstream.rsp_rdata = t_rsp_rdata[0];
                upstream.rsp_resp  = t_rsp_resp[0];
            end
            TGT_MEM1: begin
                fwd_ready          = t_req_ready[1];
                upstream.rsp_valid = t_rsp_valid[1];
                upstream.rsp_rdata = t_rsp_rdata[1];
                upstream.rsp_resp  = t_rsp_resp[1];
            end
            default: ;
        endcase
    end

    assign upstream.req_ready = !busy;
    assign up_req_xfer        = upstream.req_valid && !busy;
    assign up_rsp_xfer        = upstream.rsp_valid && upstream.rsp_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            fwd_valid <= 1'b0;
            err_valid <= 1'b0;
            tgt_sel   <= TGT_NONE;
        end else if (up_req_xfer) begin
            busy      <= 1'b1;
            tgt_sel   <= hit_tgt;
            fwd_valid <= (hit_tgt != TGT_NONE);
            err_valid <= (hit_tgt == TGT_NONE);  // decode error answered next cycle
        end else begin
            if (fwd_valid && fwd_ready) begin
                fwd_valid <= 1'b0;
            end
            if (up_rsp_xfer) begin
                busy      <= 1'b0;
                err_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (up_req_xfer) begin
            q_write <= upstream.req_write;
            q_addr  <= hit_off;
            q_wdata <= upstream.req_wdata;
        end
    end

endmodule

// File: logic/axil_if.sv
`timescale 1ns/1ns

interface axil_if;
    import axil_pkg::*;

    logic  req_valid;
    logic  req_ready;
    logic  req_write;
    addr_t req_addr;
    data_t req_wdata;

    logic  rsp_valid;
    logic  rsp_ready;
    data_t rsp_rdata;
    resp_t rsp_resp;

    modport master (
        output req_valid, req_write, req_addr, req_wdata, rsp_ready,
        input  req_ready, rsp_valid, rsp_rdata, rsp_resp
    );

    modport slave (
        input  req_valid, req_write, req_addr, req_wdata, rsp_ready,
        output req_ready, rsp_valid, rsp_rdata, rsp_resp
    );

endinterface

// File: logic/axil_pkg.sv
package axil_pkg;

    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int NUM_MASTERS = 2;  // cpu and dma

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // same codes as the AXI response field
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_t;

endpackage

// File: logic/fabric_arbiter.sv
`timescale 1ns/1ns

module fabric_arbiter (
    input  logic   clk,
    input  logic   reset,
    input  logic   pause_req,
    output logic   pause_ack,
    axil_if.slave  masters [axil_pkg::NUM_MASTERS],
    axil_if.master granted
);
    import axil_pkg::*;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_REQ,
        ARB_RSP
    } arb_state_t;

    arb_state_t state;

    logic sel;     // master that owns the fabric
    logic rr_ptr;  // master with priority on the next pick
    logic pick;

    logic [NUM_MASTERS-1:0] m_req_valid;
    logic [NUM_MASTERS-1:0] m_req_write;
    logic [NUM_MASTERS-1:0] m_rsp_ready;
    addr_t                  m_req_addr  [NUM_MASTERS];
    data_t                  m_req_wdata [NUM_MASTERS];

    logic  m_req_xfer;
    logic  fwd_valid;
    logic  q_write;
    addr_t q_addr;
    data_t q_wdata;

    for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_master
        assign m_req_valid[i] = masters[i].req_valid;
        assign m_req_write[i] = masters[i].req_write;
        assign m_req_addr[i]  = masters[i].req_addr;
        assign m_req_wdata[i] = masters[i].req_wdata;
        assign m_rsp_ready[i] = masters[i].rsp_ready;

        assign masters[i].req_ready = (state == ARB_REQ) && (sel == 1'(i));
        assign masters[i].rsp_valid = (state == ARB_RSP) && (sel == 1'(i)) && granted.rsp_valid;
        assign masters[i].rsp_rdata = granted.rsp_rdata;  // only valid goes to the owner
        assign masters[i].rsp_resp  = granted.rsp_resp;
    end

    always_comb begin
        pick = rr_ptr;
        if (!m_req_valid[rr_ptr]) begin
            pick = ~rr_ptr;
        end
    end

    assign m_req_xfer = (state == ARB_REQ) && m_req_valid[sel];

    assign granted.req_valid = fwd_valid;
    assign granted.req_write = q_write;
    assign granted.req_addr  = q_addr;
    assign granted.req_wdata = q_wdata;
    assign granted.rsp_ready = (state == ARB_RSP) && m_rsp_ready[sel];

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ARB_IDLE;
            sel       <= 1'b0;
            rr_ptr    <= 1'b0;
            fwd_valid <= 1'b0;
            pause_ack <= 1'b0;
        end else begin
            pause_ack <= pause_req && (state == ARB_IDLE);  // idle means nothing in flight
            case (state)
                ARB_IDLE: begin
                    if (!pause_req && (|m_req_valid)) begin
                        sel   <= pick;
                        state <= ARB_REQ;
                    end
                end
                ARB_REQ: begin
                    if (m_req_xfer) begin
                        fwd_valid <= 1'b1;
                        state     <= ARB_RSP;
                    end
                end
                ARB_RSP: begin
                    if (granted.req_valid && granted.req_ready) begin
                        fwd_valid <= 1'b0;
                    end
                    if (granted.rsp_valid && granted.rsp_ready) begin
                        rr_ptr <= ~sel;  // other master goes first next time
                        state  <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (m_req_xfer) begin
            q_write <= m_req_write[sel];
            q_addr  <= m_req_addr[sel];
            q_wdata <= m_req_wdata[sel];
        end
    end

endmodule

// File: logic/fabric_hsdom.sv
`timescale 1ns/1ns

module fabric_hsdom (
    input  logic            clk,
    input  logic            reset,
    input  logic            pause_req,
    output logic            pause_ack,
    input  logic            m_req_valid [axil_pkg::NUM_MASTERS],
    output logic            m_req_ready [axil_pkg::NUM_MASTERS],
    input  logic            m_req_write [axil_pkg::NUM_MASTERS],
    input  axil_pkg::addr_t m_req_addr  [axil_pkg::NUM_MASTERS],
    input  axil_pkg::data_t m_req_wdata [axil_pkg::NUM_MASTERS],
    output logic            m_rsp_valid [axil_pkg::NUM_MASTERS],
    input  logic            m_rsp_ready [axil_pkg::NUM_MASTERS],
    output axil_pkg::data_t m_rsp_rdata [axil_pkg::NUM_MASTERS],
    output axil_pkg::resp_t m_rsp_resp  [axil_pkg::NUM_MASTERS]
);
    import axil_pkg::*;
    import fabric_map_pkg::*;

    axil_if m_bus [NUM_MASTERS] ();
    axil_if g_bus ();
    axil_if t_bus [NUM_TARGETS] ();

    for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_port
        assign m_bus[i].req_valid = m_req_valid[i];
        assign m_bus[i].req_write = m_req_write[i];
        assign m_bus[i].req_addr  = m_req_addr[i];
        assign m_bus[i].req_wdata = m_req_wdata[i];
        assign m_bus[i].rsp_ready = m_rsp_ready[i];

        assign m_req_ready[i] = m_bus[i].req_ready;
        assign m_rsp_valid[i] = m_bus[i].rsp_valid;
        assign m_rsp_rdata[i] = m_bus[i].rsp_rdata;
        assign m_rsp_resp[i]  = m_bus[i].rsp_resp;
    end

    fabric_arbiter i_arbiter (
        .clk       (clk),
        .reset     (reset),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .masters   (m_bus),
        .granted   (g_bus)
    );

    addr_decoder i_decoder (
        .clk      (clk),
        .reset    (reset),
        .upstream (g_bus),
        .targets  (t_bus)
    );

    mem_slave #(
        .DEPTH_WORDS (MEM0_WORDS)
    ) i_mem0 (
        .clk   (clk),
        .reset (reset),
        .bus   (t_bus[0])
    );

    mem_slave #(
        .DEPTH_WORDS (MEM1_WORDS)
    ) i_mem1 (
        .clk   (clk),
        .reset (reset),
        .bus   (t_bus[1])
    );

endmodule

// File: logic/fabric_map_pkg.sv
package fabric_map_pkg;

    localparam int NUM_TARGETS = 2;

    localparam axil_pkg::addr_t MEM0_BASE  = 32'h0000_0000;
    localparam int              MEM0_WORDS = 256;
    localparam axil_pkg::addr_t MEM0_BYTES = axil_pkg::addr_t'(MEM0_WORDS * 4);

    localparam axil_pkg::addr_t MEM1_BASE  = 32'h0001_0000;
    localparam int              MEM1_WORDS = 64;
    localparam axil_pkg::addr_t MEM1_BYTES = axil_pkg::addr_t'(MEM1_WORDS * 4);

    typedef enum logic [1:0] {
        TGT_MEM0 = 2'd0,
        TGT_MEM1 = 2'd1,
        TGT_NONE = 2'd2  // answered by the decoder itself
    } target_t;

endpackage

// File: logic/mem_slave.sv
`timescale 1ns/1ns

module mem_slave #(
    parameter int DEPTH_WORDS = 256
) (
    input  logic  clk,
    input  logic  reset,
    axil_if.slave bus
);
    import axil_pkg::*;

    localparam int IDX_W = $clog2(DEPTH_WORDS);

    data_t            mem [DEPTH_WORDS];
    data_t            rdata_q;
    logic             rsp_pending;
    logic [IDX_W-1:0] idx;
    logic             req_xfer;

    assign idx      = bus.req_addr[IDX_W+1:2];  // word offset within the window
    assign req_xfer = bus.req_valid && bus.req_ready;

    assign bus.req_ready = !rsp_pending;
    assign bus.rsp_valid = rsp_pending;
    assign bus.rsp_rdata = rdata_q;
    assign bus.rsp_resp  = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_pending <= 1'b0;
            for (int i = 0; i < DEPTH_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (req_xfer) begin
            rsp_pending <= 1'b1;
            if (bus.req_write) begin
                mem[idx] <= bus.req_wdata;
            end
        end else if (bus.rsp_valid && bus.rsp_ready) begin
            rsp_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_xfer) begin
            rdata_q <= bus.req_write ? '0 : mem[idx];  // writes answer with zero data
        end
    end

endmodule

// File: project.f
logic/axil_pkg.sv
logic/fabric_map_pkg.sv
logic/axil_if.sv
logic/fabric_arbiter.sv
logic/addr_decoder.sv
logic/mem_slave.sv
logic/fabric_hsdom.sv
tb/fabric_checker.sv
tb/fabric_sva.sv
tb/fabric_hsdom_tb.sv

// File: run.sh
#!/bin/sh
# build and run the fabric testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module fabric_hsdom_tb -f project.f -o fabric_sim

./obj_dir/fabric_sim | tee sim.log

grep -q "TEST PASSED" sim.log

// File: tb/fabric_checker.sv
`timescale 1ns/1ns

module fabric_checker (
    input logic            clk,
    input logic            reset,
    input logic            pause_ack,
    input logic            req_valid [axil_pkg::NUM_MASTERS],
    input logic            req_ready [axil_pkg::NUM_MASTERS],
    input logic            rsp_valid [axil_pkg::NUM_MASTERS],
    input logic            rsp_ready [axil_pkg::NUM_MASTERS],
    input axil_pkg::data_t rsp_rdata [axil_pkg::NUM_MASTERS],
    input axil_pkg::resp_t rsp_resp  [axil_pkg::NUM_MASTERS]
);
    import axil_pkg::*;

    int errors = 0;

    // expected responses, oldest first, one set per master
    string name_q0[$];
    string name_q1[$];
    data_t rdata_q0[$];
    data_t rdata_q1[$];
    resp_t resp_q0[$];
    resp_t resp_q1[$];

    function automatic void post_expected(input int m, input string name,
                                          input data_t rdata, input resp_t resp);
        if (m == 0) begin
            name_q0.push_back(name);
            rdata_q0.push_back(rdata);
            resp_q0.push_back(resp);
        end else begin
            name_q1.push_back(name);
            rdata_q1.push_back(rdata);
            resp_q1.push_back(resp);
        end
    endfunction

    function automatic int pending();
        return name_q0.size() + name_q1.size();
    endfunction

    task automatic compare(input int m, input string name, input data_t exp_rdata,
                           input resp_t exp_resp);
        if (rsp_rdata[m] !== exp_rdata || rsp_resp[m] !== exp_resp) begin
            $display("ERROR %s: expected rdata %h resp %0d, actual rdata %h resp %0d",
                     name, exp_rdata, exp_resp, rsp_rdata[m], rsp_resp[m]);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (rsp_valid[0] && rsp_ready[0]) begin
                if (name_q0.size() == 0) begin
                    $display("master 0 got a response it never asked for");
                    errors++;
                end else begin
                    compare(0, name_q0.pop_front(), rdata_q0.pop_front(), resp_q0.pop_front());
                end
            end
            if (rsp_valid[1] && rsp_ready[1]) begin
                if (name_q1.size() == 0) begin
                    $display("master 1 got a response it never asked for");
                    errors++;
                end else begin
                    compare(1, name_q1.pop_front(), rdata_q1.pop_front(), resp_q1.pop_front());
                end
            end
            if (pause_ack && ((req_valid[0] && req_ready[0]) || (req_valid[1] && req_ready[1])))
            begin
                $display("a request was accepted while the fabric was paused");
                errors++;
            end
        end
    end

endmodule

// File: tb/fabric_hsdom_tb.sv
`timescale 1ns/1ns

module fabric_hsdom_tb;
    import axil_pkg::*;

    localparam int MAX_VEC = 64;

    logic  clk;
    logic  reset;
    logic  pause_req;
    logic  pause_ack;
    logic  req_valid [NUM_MASTERS];
    logic  req_ready [NUM_MASTERS];
    logic  req_write [NUM_MASTERS];
    addr_t req_addr  [NUM_MASTERS];
    data_t req_wdata [NUM_MASTERS];
    logic  rsp_valid [NUM_MASTERS];
    logic  rsp_ready [NUM_MASTERS];
    data_t rsp_rdata [NUM_MASTERS];
    resp_t rsp_resp  [NUM_MASTERS];

    // one entry per vector line
    string vec_name  [MAX_VEC];
    int    vec_master[MAX_VEC];
    string vec_op    [MAX_VEC];
    addr_t vec_addr  [MAX_VEC];
    data_t vec_wdata [MAX_VEC];
    data_t vec_rdata [MAX_VEC];
    int    vec_resp  [MAX_VEC];
    int    n_vec;

    int          accepted_cnt;  // lines whose request has gone into the fabric
    int          tb_errors;
    logic [31:0] lfsr;

    fabric_hsdom i_dut (
        .clk         (clk),
        .reset       (reset),
        .pause_req   (pause_req),
        .pause_ack   (pause_ack),
        .m_req_valid (req_valid),
        .m_req_ready (req_ready),
        .m_req_write (req_write),
        .m_req_addr  (req_addr),
        .m_req_wdata (req_wdata),
        .m_rsp_valid (rsp_valid),
        .m_rsp_ready (rsp_ready),
        .m_rsp_rdata (rsp_rdata),
        .m_rsp_resp  (rsp_resp)
    );

    fabric_checker i_checker (
        .clk       (clk),
        .reset     (reset),
        .pause_ack (pause_ack),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .rsp_resp  (rsp_resp)
    );

    bind fabric_hsdom fabric_sva i_sva (
        .clk         (clk),
        .reset       (reset),
        .pause_ack   (pause_ack),
        .m_req_valid (m_req_valid),
        .m_req_ready (m_req_ready),
        .m_req_write (m_req_write),
        .m_req_addr  (m_req_addr),
        .m_req_wdata (m_req_wdata),
        .m_rsp_valid (m_rsp_valid),
        .m_rsp_ready (m_rsp_ready),
        .m_rsp_rdata (m_rsp_rdata),
        .m_rsp_resp  (m_rsp_resp)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_step(lfsr);
            v    = (v << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    cnt;
        string line;
        fd    = $fopen("tb/fabric_vectors.txt", "r");
        n_vec = 0;
        if (fd == 0) begin
            $display("could not open the vector file tb/fabric_vectors.txt");
            tb_errors++;
            return;
        end
        while (!$feof(fd) && n_vec < MAX_VEC) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#") continue;
            cnt = $sscanf(line, "%s %d %s %h %h %h %d", vec_name[n_vec], vec_master[n_vec],
                          vec_op[n_vec], vec_addr[n_vec], vec_wdata[n_vec],
                          vec_rdata[n_vec], vec_resp[n_vec]);
            if (cnt == 7) n_vec++;
        end
        $fclose(fd);
    endtask

    // lines go into the fabric in file order
    task automatic wait_turn(input int i);
        int t;
        t = 0;
        while (accepted_cnt < i && t < 600) begin
            @(negedge clk);
            t++;
        end
        if (accepted_cnt < i) begin
            $display("timeout: line %s never got its turn", vec_name[i]);
            tb_errors++;
        end
    endtask

    task automatic run_master(input int m);
        int gap;
        int stall;
        int t;
        for (int i = 0; i < n_vec; i++) begin
            if (vec_master[i] != m || vec_op[i] == "P") continue;
            wait_turn(i);
            take_bits(2, gap);
            repeat (gap) @(negedge clk);
            i_checker.post_expected(m, vec_name[i], vec_rdata[i], resp_t'(vec_resp[i]));
            req_valid[m] = 1'b1;
            req_write[m] = (vec_op[i] == "W");
            req_addr[m]  = vec_addr[i];
            req_wdata[m] = vec_wdata[i];
            t = 0;
            while (!req_ready[m] && t < 200) begin
                @(negedge clk);
                t++;
            end
            if (!req_ready[m]) begin
                $display("timeout: master %0d request of %s was never accepted", m, vec_name[i]);
                tb_errors++;
            end
            @(negedge clk);  // transfer happened on the edge in between
            req_valid[m] = 1'b0;
            accepted_cnt++;
            t = 0;
            while (!rsp_valid[m] && t < 50) begin
                @(negedge clk);
                t++;
            end
            if (!rsp_valid[m]) begin
                $display("timeout: master %0d got no response for %s", m, vec_name[i]);
                tb_errors++;
            end
            take_bits(2, stall);
            repeat (stall) @(negedge clk);  // back-pressure
            rsp_ready[m] = 1'b1;
            @(negedge clk);
            rsp_ready[m] = 1'b0;
        end
    endtask

    task automatic run_pause();
        int t;
        for (int i = 0; i < n_vec; i++) begin
            if (vec_op[i] != "P") continue;
            wait_turn(i);
            pause_req = 1'b1;
            accepted_cnt++;  // later lines queue up behind the pause
            t = 0;
            while (!pause_ack && t < 40) begin
                @(negedge clk);
                t++;
            end
            if (!pause_ack) begin
                $display("timeout: pause_ack did not rise for %s", vec_name[i]);
                tb_errors++;
            end
            repeat (8) @(negedge clk);
            pause_req = 1'b0;
            t = 0;
            while (pause_ack && t < 4) begin
                @(negedge clk);
                t++;
            end
            if (pause_ack) begin
                $display("pause_ack stayed high after pause_req dropped in %s", vec_name[i]);
                tb_errors++;
            end
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        pause_req    = 1'b0;
        accepted_cnt = 0;
        tb_errors    = 0;
        lfsr         = 32'h8cf6;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            req_valid[m] = 1'b0;
            req_write[m] = 1'b0;
            req_addr[m]  = '0;
            req_wdata[m] = '0;
            rsp_ready[m] = 1'b0;
        end
        load_vectors();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if (pause_ack || req_ready[0] || req_ready[1] || rsp_valid[0] || rsp_valid[1]) begin
            $display("outputs were not low after reset");
            tb_errors++;
        end
        fork
            run_master(0);
            run_master(1);
            run_pause();
        join
        repeat (4) @(negedge clk);
        if (i_checker.pending() != 0) begin
            $display("%0d expected responses never arrived", i_checker.pending());
            tb_errors++;
        end
        $display("errors: checker %0d, testbench %0d", i_checker.errors, tb_errors);
        if (i_checker.errors == 0 && tb_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tb/fabric_sva.sv
`timescale 1ns/1ns

module fabric_sva (
    input logic            clk,
    input logic            reset,
    input logic            pause_ack,
    input logic            m_req_valid [axil_pkg::NUM_MASTERS],
    input logic            m_req_ready [axil_pkg::NUM_MASTERS],
    input logic            m_req_write [axil_pkg::NUM_MASTERS],
    input axil_pkg::addr_t m_req_addr  [axil_pkg::NUM_MASTERS],
    input axil_pkg::data_t m_req_wdata [axil_pkg::NUM_MASTERS],
    input logic            m_rsp_valid [axil_pkg::NUM_MASTERS],
    input logic            m_rsp_ready [axil_pkg::NUM_MASTERS],
    input axil_pkg::data_t m_rsp_rdata [axil_pkg::NUM_MASTERS],
    input axil_pkg::resp_t m_rsp_resp  [axil_pkg::NUM_MASTERS]
);
    import axil_pkg::*;

    logic [NUM_MASTERS-1:0] owner;  // master with a transaction in flight

    always_ff @(posedge clk) begin
        if (reset) begin
            owner <= '0;
        end else begin
            for (int i = 0; i < NUM_MASTERS; i++) begin
                if (m_req_valid[i] && m_req_ready[i]) begin
                    owner[i] <= 1'b1;
                end else if (m_rsp_valid[i] && m_rsp_ready[i]) begin
                    owner[i] <= 1'b0;
                end
            end
        end
    end

    for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_chk
        a_req_hold: assert property (@(posedge clk) disable iff (reset)
            m_req_valid[i] && !m_req_ready[i] |=> m_req_valid[i] && $stable(m_req_write[i])
                && $stable(m_req_addr[i]) && $stable(m_req_wdata[i]))
            else $error("request %0d changed before its transfer", i);

        a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
            m_rsp_valid[i] && !m_rsp_ready[i] |=> m_rsp_valid[i]
                && $stable(m_rsp_rdata[i]) && $stable(m_rsp_resp[i]))
            else $error("response %0d changed while stalled", i);
    end

    a_pause_no_grant: assert property (@(posedge clk) disable iff (reset)
        pause_ack |-> !m_req_ready[0] && !m_req_ready[1])
        else $error("grant while paused");

    a_one_grant: assert property (@(posedge clk) disable iff (reset)
        (|owner) |-> !m_req_ready[0] && !m_req_ready[1])
        else $error("a master was granted while another transaction was in flight");

endmodule

// File: tb/fabric_vectors.txt
# name master op(W/R/P) addr wdata exp_rdata exp_resp(0 okay, 3 decerr)
# hex for addr and data, pause lines ignore the other columns
rst_mem0      0 R 00000010 00000000 00000000 0
rst_mem1      1 R 00010020 00000000 00000000 0
wr_mem0_first 0 W 00000000 a5a50000 00000000 0
wr_mem0_last  0 W 000003fc a5a50000 00000000 0
wr_mem1_first 0 W 00010000 a5a50001 00000000 0
wr_mem1_last  0 W 000100fc a5a50001 00000000 0
rd_mem0_first 0 R 00000000 00000000 a5a50000 0
rd_mem0_last  0 R 000003fc 00000000 a5a50000 0
rd_mem1_first 0 R 00010000 00000000 a5a50001 0
rd_mem1_last  0 R 000100fc 00000000 a5a50001 0
dec_rd_gap    0 R 00000400 00000000 00000000 3
dec_wr_high   1 W 00020000 12345678 00000000 3
m1_wr_shared  1 W 00010040 55aa0001 00000000 0
m0_wr_other   0 W 00000080 0000beef 00000000 0
m0_rd_shared  0 R 00010040 00000000 55aa0001 0
pause_mid     0 P 00000000 00000000 00000000 0
m1_after_wr   1 W 00000100 c0ffee11 00000000 0
m0_after_rd   0 R 00000080 00000000 0000beef 0
m0_rd_m1wr    0 R 00000100 00000000 c0ffee11 0
m1_rd_dec     1 R 00030000 00000000 00000000 3
